/* tb.f */
cu_pkg.sv
decode_if.sv
opcode_decoder.sv
cu_sequencer.sv
control_word_gen.sv
control_unit.sv
tb_control_unit.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_control_unit
FILELIST = tb.f
BUILD    = obj_dir
LOG      = sim.log
PASS_MSG = Simulation passed

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* tb_control_unit.sv */
`timescale 1ns/100ps

module tb_control_unit
	import cu_pkg::*;
();

	localparam int NUM_INSTR  = 400;
	localparam int RESET_CYC  = 8;
	localparam int NUM_LEGAL  = 27;
	localparam int TIMEOUT_NS = (RESET_CYC + NUM_INSTR * 9 + 100) * 10; // Up to 9 cycles each

	typedef struct packed {
		logic      ir_load;
		logic      mar_load;
		logic      pc_load;
		logic      pc_inc;
		logic      a_load;
		logic      b_load;
		logic      ccr_load;
		logic      write;
		alu_sel_t  alu_sel;
		bus1_sel_t bus1_sel;
		bus2_sel_t bus2_sel;
	} cword_t;

	typedef struct packed {
		cword_t w;
		int     test_id; // Index into the per-test counters
	} exp_t;

	logic      Clk;
	logic      Reset;
	opcode_t   ir;
	ccr_t      ccr_result;
	logic      ir_load;
	logic      mar_load;
	logic      pc_load;
	logic      pc_inc;
	logic      a_load;
	logic      b_load;
	logic      ccr_load;
	logic      write;
	alu_sel_t  alu_sel;
	bus1_sel_t bus1_sel;
	bus2_sel_t bus2_sel;

	exp_t     exp_q[$]; // Expected words, one per cycle
	int       checks [6];
	int       fails [6];
	int       instr_done;
	logic     running;
	logic     started;
	logic     load_next; // IR load seen, next edge brings a new opcode
	logic     cur_src_b;
	logic     cur_dst_b;
	alu_sel_t cur_sel;

	opcode_t legal_ops [NUM_LEGAL] = '{LDA_IMM, LDA_DIR, LDB_IMM, LDB_DIR, STA_DIR, STB_DIR,
		ADD_AB, SUB_AB, AND_AB, OR_AB, INCA, INCB, DECA, DECB, XOR_AB, NOTA, NOTB, ADDAB_LDB,
		BRA, BMI, BPL, BEQ, BNE, BVS, BVC, BCS, BCC};

	control_unit u_control_unit (
		.Clk        (Clk),
		.Reset      (Reset),
		.ir         (ir),
		.ccr_result (ccr_result),
		.ir_load    (ir_load),
		.mar_load   (mar_load),
		.pc_load    (pc_load),
		.pc_inc     (pc_inc),
		.a_load     (a_load),
		.b_load     (b_load),
		.ccr_load   (ccr_load),
		.alu_sel    (alu_sel),
		.bus1_sel   (bus1_sel),
		.bus2_sel   (bus2_sel),
		.write      (write)
	);

	always #5 Clk = ~Clk;

	// Expected control word for one step of the current instruction
	function automatic cword_t step_word(micro_op_e u);
		cword_t w;
		w          = '0;
		w.alu_sel  = ALU_ADD;
		w.bus1_sel = BUS1_PC;
		w.bus2_sel = BUS2_BUS1;
		if (u inside {UOP_PC_INC, UOP_IR_LOAD, UOP_MAR_MEM, UOP_WAIT_MEM, UOP_REG_MEM, UOP_PC_MEM})
			w.bus2_sel = BUS2_MEM;
		if (u inside {UOP_STORE, UOP_ALU, UOP_IDLE})
			w.bus2_sel = BUS2_ALU;
		case (u)
			UOP_MAR_PC, UOP_MAR_MEM: w.mar_load = 1'b1;
			UOP_PC_INC:              w.pc_inc = 1'b1;
			UOP_IR_LOAD:             w.ir_load = 1'b1;
			UOP_PC_MEM:              w.pc_load = 1'b1;
			UOP_REG_MEM:
			begin
				w.a_load = !cur_dst_b;
				w.b_load = cur_dst_b;
			end
			UOP_STORE:
			begin
				w.write    = 1'b1;
				w.bus1_sel = cur_src_b ? BUS1_B : BUS1_A;
			end
			UOP_ALU:
			begin
				w.a_load   = !cur_dst_b;
				w.b_load   = cur_dst_b;
				w.ccr_load = 1'b1;
				w.alu_sel  = cur_sel;
				w.bus1_sel = cur_src_b ? BUS1_B : BUS1_A;
			end
			default: w.write = 1'b0; // Decode and idle keep the defaults
		endcase
		return w;
	endfunction

	function automatic string test_label(int t);
		case (t)
			0:       return "reset";
			1:       return "fetch and decode";
			2:       return "loads and stores";
			3:       return "ALU operations";
			4:       return "branches";
			default: return "illegal opcodes";
		endcase
	endfunction

	task automatic push_step(micro_op_e u, int t);
		exp_t e;
		e.w       = step_word(u);
		e.test_id = t;
		exp_q.push_back(e);
	endtask

	task automatic push_fetch(int first_t);
		push_step(UOP_MAR_PC, first_t);
		push_step(UOP_PC_INC, 1);
		push_step(UOP_IR_LOAD, 1);
		push_step(UOP_DECODE, 1);
	endtask

	// Execute steps straight from the instruction tables
	task automatic push_exec(opcode_t op, ccr_t f);
		logic taken;
		cur_src_b = (op == STB_DIR) || (op == INCB) || (op == DECB) || (op == NOTB);
		cur_dst_b = (op inside {LDB_IMM, LDB_DIR, INCB, DECB, NOTB, ADDAB_LDB});
		case (op)
			SUB_AB:       cur_sel = ALU_SUB;
			AND_AB:       cur_sel = ALU_AND;
			OR_AB:        cur_sel = ALU_OR;
			INCA, INCB:   cur_sel = ALU_INC;
			DECA, DECB:   cur_sel = ALU_DEC;
			XOR_AB:       cur_sel = ALU_XOR;
			NOTA, NOTB:   cur_sel = ALU_NOT;
			default:      cur_sel = ALU_ADD;
		endcase
		case (op)
			BMI:     taken = f[FLAG_N];
			BPL:     taken = !f[FLAG_N];
			BEQ:     taken = f[FLAG_Z];
			BNE:     taken = !f[FLAG_Z];
			BVS:     taken = f[FLAG_V];
			BVC:     taken = !f[FLAG_V];
			BCS:     taken = f[FLAG_C];
			BCC:     taken = !f[FLAG_C];
			default: taken = 1'b1; // BRA
		endcase
		case (op)
			LDA_IMM, LDB_IMM, LDA_DIR, LDB_DIR, STA_DIR, STB_DIR:
			begin
				push_step(UOP_MAR_PC, 2);
				push_step(UOP_PC_INC, 2);
				if (op inside {LDA_DIR, LDB_DIR, STA_DIR, STB_DIR})
					push_step(UOP_MAR_MEM, 2);
				if (op inside {LDA_DIR, LDB_DIR})
					push_step(UOP_WAIT_MEM, 2);
				push_step((op inside {STA_DIR, STB_DIR}) ? UOP_STORE : UOP_REG_MEM, 2);
			end
			ADD_AB, SUB_AB, AND_AB, OR_AB, INCA, INCB, DECA, DECB, XOR_AB, NOTA, NOTB, ADDAB_LDB:
				push_step(UOP_ALU, 3);
			BRA, BMI, BPL, BEQ, BNE, BVS, BVC, BCS, BCC:
			begin
				if (taken)
				begin
					push_step(UOP_MAR_PC, 4);
					push_step(UOP_WAIT_MEM, 4);
					push_step(UOP_PC_MEM, 4);
				end
				else
					push_step(UOP_PC_INC, 4); // Step over the target byte
			end
			default: push_step(UOP_IDLE, 5);
		endcase
	endtask

	task automatic check_field(string name, logic [2:0] exp, logic [2:0] act, int t);
		assert (exp === act)
		else
		begin
			$display("FAIL time=%0t signal=%s expected=%0h actual=%0h", $time, name, exp, act);
			fails[t] = fails[t] + 1;
		end
	endtask

	task automatic check_word(exp_t e);
		checks[e.test_id] = checks[e.test_id] + 1;
		check_field("ir_load", {2'b0, e.w.ir_load}, {2'b0, ir_load}, e.test_id);
		check_field("mar_load", {2'b0, e.w.mar_load}, {2'b0, mar_load}, e.test_id);
		check_field("pc_load", {2'b0, e.w.pc_load}, {2'b0, pc_load}, e.test_id);
		check_field("pc_inc", {2'b0, e.w.pc_inc}, {2'b0, pc_inc}, e.test_id);
		check_field("a_load", {2'b0, e.w.a_load}, {2'b0, a_load}, e.test_id);
		check_field("b_load", {2'b0, e.w.b_load}, {2'b0, b_load}, e.test_id);
		check_field("ccr_load", {2'b0, e.w.ccr_load}, {2'b0, ccr_load}, e.test_id);
		check_field("write", {2'b0, e.w.write}, {2'b0, write}, e.test_id);
		check_field("alu_sel", e.w.alu_sel, alu_sel, e.test_id);
		check_field("bus1_sel", {1'b0, e.w.bus1_sel}, {1'b0, bus1_sel}, e.test_id);
		check_field("bus2_sel", {1'b0, e.w.bus2_sel}, {1'b0, bus2_sel}, e.test_id);
	endtask

	task automatic report_test(int t);
		$display("Test %0d %s: %0d cycles checked, %0d errors", t + 1, test_label(t),
			checks[t], fails[t]);
	endtask

	// Outputs are settled at the falling edge
	always @(negedge Clk)
	begin
		exp_t e;
		if (running)
		begin
			if (exp_q.size() == 0)
			begin
				if (started)
				begin
					instr_done = instr_done + 1;
					push_fetch(1);
				end
				else
				begin
					started = 1'b1;
					push_fetch(0); // First word after reset
				end
			end
			e = exp_q.pop_front();
			check_word(e);
			if (e.w.ir_load)
				load_next = 1'b1;
		end
	end

	always @(posedge Clk)
	begin
		opcode_t op;
		ccr_t    f;
		int      idx;
		if (load_next)
		begin
			load_next = 1'b0;
			idx = $urandom_range(0, NUM_LEGAL - 1);
			if ($urandom_range(0, 7) == 0)
				op = opcode_t'($urandom_range(0, 255)); // Mostly unknown opcodes
			else
				op = legal_ops[idx];
			f = ccr_t'($urandom_range(0, 15));
			ir         <= op;
			ccr_result <= f;
			push_exec(op, f);
		end
	end

	initial
	begin
		exp_t e;
		int   total_checks;
		int   total_fails;
		Clk        = 1'b0;
		Reset      = 1'b0;
		ir         = '0;
		ccr_result = '0;
		running    = 1'b0;
		started    = 1'b0;
		load_next  = 1'b0;
		instr_done = 0;
		cur_src_b  = 1'b0;
		cur_dst_b  = 1'b0;
		cur_sel    = ALU_ADD;
		void'($urandom(30));

		e.w       = step_word(UOP_MAR_PC);
		e.test_id = 0;
		repeat (RESET_CYC)
		begin
			@(negedge Clk);
			check_word(e);
		end
		@(posedge Clk);
		Reset   <= 1'b1;
		running = 1'b1;
		@(negedge Clk);
		@(posedge Clk);
		report_test(0);

		while (instr_done < NUM_INSTR)
			@(posedge Clk);

		total_checks = checks[0];
		total_fails  = fails[0];
		for (int t = 1; t < 6; t++)
		begin
			report_test(t);
			total_checks = total_checks + checks[t];
			total_fails  = total_fails + fails[t];
		end
		$display("Totals: %0d instructions, %0d cycles checked, %0d errors", instr_done,
			total_checks, total_fails);
		if (total_fails == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

	// Watchdog
	initial
	begin
		#(TIMEOUT_NS);
		$display("Timeout: only %0d of %0d instructions completed in time", instr_done,
			NUM_INSTR);
		$display("Simulation failed");
		$finish;
	end

endmodule

/* control_unit.sv */
`timescale 1ns/100ps

module control_unit
	import cu_pkg::*;
(
	input  logic      Clk,
	input  logic      Reset,
	input  opcode_t   ir,
	input  ccr_t      ccr_result,
	output logic      ir_load,
	output logic      mar_load,
	output logic      pc_load,
	output logic      pc_inc,
	output logic      a_load,
	output logic      b_load,
	output logic      ccr_load,
	output alu_sel_t  alu_sel,
	output bus1_sel_t bus1_sel,
	output bus2_sel_t bus2_sel,
	output logic      write
);

	micro_op_e uop; // Current step from the sequencer

	decode_if u_dec_if ();

	opcode_decoder u_opcode_decoder (
		.ir  (ir),
		.dec (u_dec_if.decoder)
	);

	cu_sequencer u_cu_sequencer (
		.Clk        (Clk),
		.Reset      (Reset),
		.ccr_result (ccr_result),
		.dec        (u_dec_if.sequencer),
		.uop        (uop)
	);

	control_word_gen u_control_word_gen (
		.uop      (uop),
		.dec      (u_dec_if.word),
		.ir_load  (ir_load),
		.mar_load (mar_load),
		.pc_load  (pc_load),
		.pc_inc   (pc_inc),
		.a_load   (a_load),
		.b_load   (b_load),
		.ccr_load (ccr_load),
		.write    (write),
		.alu_sel  (alu_sel),
		.bus1_sel (bus1_sel),
		.bus2_sel (bus2_sel)
	);

endmodule

/* control_word_gen.sv */
`timescale 1ns/100ps

module control_word_gen
	import cu_pkg::*;
(
	input  micro_op_e  uop,
	decode_if.word     dec,
	output logic       ir_load,
	output logic       mar_load,
	output logic       pc_load,
	output logic       pc_inc,
	output logic       a_load,
	output logic       b_load,
	output logic       ccr_load,
	output logic       write,
	output alu_sel_t   alu_sel,
	output bus1_sel_t  bus1_sel,
	output bus2_sel_t  bus2_sel
);

	bus1_sel_t src_bus1;
	logic      dst_is_a;

	assign src_bus1 = (dec.src_reg == REG_A) ? BUS1_A : BUS1_B;
	assign dst_is_a = (dec.dst_reg == REG_A);

	always_comb
	begin
		ir_load  = 1'b0;
		mar_load = 1'b0;
		pc_load  = 1'b0;
		pc_inc   = 1'b0;
		a_load   = 1'b0;
		b_load   = 1'b0;
		ccr_load = 1'b0;
		write    = 1'b0;
		alu_sel  = ALU_ADD;
		bus1_sel = BUS1_PC;
		bus2_sel = BUS2_BUS1; // PC reaches MAR through bus 2

		case (uop)
			UOP_MAR_PC: mar_load = 1'b1;
			UOP_PC_INC:
			begin
				pc_inc   = 1'b1;
				bus2_sel = BUS2_MEM;
			end
			UOP_IR_LOAD:
			begin
				ir_load  = 1'b1;
				bus2_sel = BUS2_MEM;
			end
			UOP_MAR_MEM:
			begin
				mar_load = 1'b1;
				bus2_sel = BUS2_MEM;
			end
			UOP_WAIT_MEM: bus2_sel = BUS2_MEM; // Memory read latency
			UOP_REG_MEM:
			begin
				a_load   = dst_is_a;
				b_load   = !dst_is_a;
				bus2_sel = BUS2_MEM;
			end
			UOP_STORE:
			begin
				write    = 1'b1;
				bus1_sel = src_bus1;
				bus2_sel = BUS2_ALU;
			end
			UOP_ALU:
			begin
				a_load   = dst_is_a;
				b_load   = !dst_is_a;
				ccr_load = 1'b1;
				alu_sel  = dec.alu_sel;
				bus1_sel = src_bus1;
				bus2_sel = BUS2_ALU;
			end
			UOP_PC_MEM:
			begin
				pc_load  = 1'b1; // Branch target from memory
				bus2_sel = BUS2_MEM;
			end
			UOP_IDLE: bus2_sel = BUS2_ALU;
			default:
			begin
				bus1_sel = BUS1_PC; // Decode cycle keeps the defaults
				bus2_sel = BUS2_BUS1;
			end
		endcase
	end

endmodule

/* cu_sequencer.sv */
`timescale 1ns/100ps

module cu_sequencer
	import cu_pkg::*;
(
	input  logic       Clk,
	input  logic       Reset,
	input  ccr_t       ccr_result,
	decode_if.sequencer dec,
	output micro_op_e  uop
);

	typedef enum logic [2:0] {
		PH_FETCH_MAR,
		PH_FETCH_INC,
		PH_FETCH_IR,
		PH_DECODE,
		PH_EXEC
	} phase_e;

	phase_e       phase;
	step_t        step;      // Index into the execute list
	step_t        last_step;
	instr_class_e class_q;
	logic         taken_q;
	logic         taken;

	// Selected flag against the level the branch wants
	assign taken = dec.cond_always || (ccr_result[dec.cond_bit] == dec.cond_level);

	always_ff @(posedge Clk or negedge Reset)
	begin
		if (!Reset)
		begin
			phase   <= PH_FETCH_MAR;
			step    <= '0;
			class_q <= CLS_ILLEGAL;
			taken_q <= 1'b0;
		end
		else
		begin
			case (phase)
				PH_FETCH_MAR: phase <= PH_FETCH_INC;
				PH_FETCH_INC: phase <= PH_FETCH_IR;
				PH_FETCH_IR:  phase <= PH_DECODE;
				PH_DECODE:
				begin
					phase   <= PH_EXEC;
					class_q <= dec.instr_class;
					taken_q <= taken;
				end
				PH_EXEC:
				begin
					if (step == last_step)
					begin
						phase <= PH_FETCH_MAR; // Next instruction
						step  <= '0;
					end
					else
						step <= step + 1'b1;
				end
				default: phase <= PH_FETCH_MAR;
			endcase
		end
	end

	always_comb
	begin
		uop       = UOP_IDLE;
		last_step = '0;
		case (phase)
			PH_FETCH_MAR: uop = UOP_MAR_PC;
			PH_FETCH_INC: uop = UOP_PC_INC;
			PH_FETCH_IR:  uop = UOP_IR_LOAD;
			PH_DECODE:    uop = UOP_DECODE;
			PH_EXEC:
			begin
				case (class_q)
					CLS_LOAD_IMM:
					begin
						last_step = step_t'(2);
						case (step)
							0:       uop = UOP_MAR_PC; // Operand address
							1:       uop = UOP_PC_INC;
							default: uop = UOP_REG_MEM;
						endcase
					end
					CLS_LOAD_DIR, CLS_STORE:
					begin
						last_step = (class_q == CLS_STORE) ? step_t'(3) : step_t'(4);
						case (step)
							0:       uop = UOP_MAR_PC;
							1:       uop = UOP_PC_INC;
							2:       uop = UOP_MAR_MEM; // Operand is the address
							3:       uop = (class_q == CLS_STORE) ? UOP_STORE : UOP_WAIT_MEM;
							default: uop = UOP_REG_MEM;
						endcase
					end
					CLS_ALU: uop = UOP_ALU;
					CLS_BRANCH:
					begin
						if (taken_q)
						begin
							last_step = step_t'(2);
							case (step)
								0:       uop = UOP_MAR_PC;
								1:       uop = UOP_WAIT_MEM;
								default: uop = UOP_PC_MEM;
							endcase
						end
						else
							uop = UOP_PC_INC; // Skip the target byte
					end
					default: uop = UOP_IDLE;
				endcase
			end
			default: uop = UOP_IDLE;
		endcase
	end

endmodule

/* opcode_decoder.sv */
`timescale 1ns/100ps

module opcode_decoder
	import cu_pkg::*;
(
	input  opcode_t         ir,
	decode_if.decoder       dec
);

	always_comb
	begin
		dec.instr_class = CLS_ILLEGAL; // Unknown opcodes fall through
		dec.src_reg     = REG_A;
		dec.dst_reg     = REG_A;
		dec.alu_sel     = ALU_ADD;
		dec.cond_bit    = FLAG_C;
		dec.cond_level  = 1'b1;
		dec.cond_always = 1'b0;

		case (ir)
			LDA_IMM: dec.instr_class = CLS_LOAD_IMM;
			LDB_IMM:
			begin
				dec.instr_class = CLS_LOAD_IMM;
				dec.dst_reg     = REG_B;
			end
			LDA_DIR: dec.instr_class = CLS_LOAD_DIR;
			LDB_DIR:
			begin
				dec.instr_class = CLS_LOAD_DIR;
				dec.dst_reg     = REG_B;
			end
			STA_DIR: dec.instr_class = CLS_STORE;
			STB_DIR:
			begin
				dec.instr_class = CLS_STORE;
				dec.src_reg     = REG_B;
			end

			ADD_AB, SUB_AB, AND_AB, OR_AB, INCA, DECA, XOR_AB, NOTA, ADDAB_LDB:
			begin
				dec.instr_class = CLS_ALU;
				case (ir)
					SUB_AB:    dec.alu_sel = ALU_SUB;
					AND_AB:    dec.alu_sel = ALU_AND;
					OR_AB:     dec.alu_sel = ALU_OR;
					INCA:      dec.alu_sel = ALU_INC;
					DECA:      dec.alu_sel = ALU_DEC;
					XOR_AB:    dec.alu_sel = ALU_XOR;
					NOTA:      dec.alu_sel = ALU_NOT;
					ADDAB_LDB: dec.dst_reg = REG_B; // Sum lands in B
					default:   dec.alu_sel = ALU_ADD;
				endcase
			end
			INCB, DECB, NOTB:
			begin
				dec.instr_class = CLS_ALU; // B is both operand and result
				dec.src_reg     = REG_B;
				dec.dst_reg     = REG_B;
				case (ir)
					INCB:    dec.alu_sel = ALU_INC;
					DECB:    dec.alu_sel = ALU_DEC;
					default: dec.alu_sel = ALU_NOT;
				endcase
			end

			BRA, BMI, BPL, BEQ, BNE, BVS, BVC, BCS, BCC:
			begin
				dec.instr_class = CLS_BRANCH;
				case (ir)
					BMI: dec.cond_bit = FLAG_N;
					BPL: {dec.cond_bit, dec.cond_level} = {FLAG_N, 1'b0};
					BEQ: dec.cond_bit = FLAG_Z;
					BNE: {dec.cond_bit, dec.cond_level} = {FLAG_Z, 1'b0};
					BVS: dec.cond_bit = FLAG_V;
					BVC: {dec.cond_bit, dec.cond_level} = {FLAG_V, 1'b0};
					BCS: dec.cond_bit = FLAG_C;
					BCC: dec.cond_level = 1'b0; // Carry clear
					default: dec.cond_always = 1'b1;
				endcase
			end

			default: dec.instr_class = CLS_ILLEGAL;
		endcase
	end

endmodule

/* decode_if.sv */
`timescale 1ns/100ps

interface decode_if
	import cu_pkg::*;
();
	instr_class_e instr_class;
	reg_sel_e     src_reg;     // Feeds bus 1
	reg_sel_e     dst_reg;
	alu_sel_t     alu_sel;
	flag_idx_t    cond_bit;    // Flag tested by a branch
	logic         cond_level;  // Flag value that takes the branch
	logic         cond_always; // BRA ignores the flags

	modport decoder (
		output instr_class, src_reg, dst_reg, alu_sel, cond_bit, cond_level, cond_always
	);

	modport sequencer (
		input instr_class, cond_bit, cond_level, cond_always
	);

	modport word (
		input src_reg, dst_reg, alu_sel
	);
endinterface

/* cu_pkg.sv */
package cu_pkg;

	localparam int OPCODE_W   = 8;
	localparam int ALU_SEL_W  = 3;
	localparam int BUS_SEL_W  = 2;
	localparam int CCR_W      = 4;
	localparam int FLAG_IDX_W = 2;
	localparam int STEP_W     = 3; // Longest execute list is five steps

	typedef logic [OPCODE_W-1:0]   opcode_t;
	typedef logic [ALU_SEL_W-1:0]  alu_sel_t;
	typedef logic [BUS_SEL_W-1:0]  bus1_sel_t;
	typedef logic [BUS_SEL_W-1:0]  bus2_sel_t;
	typedef logic [CCR_W-1:0]      ccr_t;
	typedef logic [FLAG_IDX_W-1:0] flag_idx_t;
	typedef logic [STEP_W-1:0]     step_t;

	// Loads and stores
	localparam opcode_t LDA_IMM = 8'h86;
	localparam opcode_t LDA_DIR = 8'h87;
	localparam opcode_t LDB_IMM = 8'h88;
	localparam opcode_t LDB_DIR = 8'h89;
	localparam opcode_t STA_DIR = 8'h96;
	localparam opcode_t STB_DIR = 8'h97;

	// Register to register ALU operations
	localparam opcode_t ADD_AB    = 8'h42; // A <= A + B
	localparam opcode_t SUB_AB    = 8'h43;
	localparam opcode_t AND_AB    = 8'h44;
	localparam opcode_t OR_AB     = 8'h45;
	localparam opcode_t INCA      = 8'h46;
	localparam opcode_t INCB      = 8'h47;
	localparam opcode_t DECA      = 8'h48;
	localparam opcode_t DECB      = 8'h49;
	localparam opcode_t XOR_AB    = 8'h4A;
	localparam opcode_t NOTA      = 8'h4B;
	localparam opcode_t NOTB      = 8'h4C;
	localparam opcode_t ADDAB_LDB = 8'h4D; // B <= A + B

	// Branches, target address follows the opcode
	localparam opcode_t BRA = 8'h20;
	localparam opcode_t BMI = 8'h21;
	localparam opcode_t BPL = 8'h22;
	localparam opcode_t BEQ = 8'h23;
	localparam opcode_t BNE = 8'h24;
	localparam opcode_t BVS = 8'h25;
	localparam opcode_t BVC = 8'h26;
	localparam opcode_t BCS = 8'h27;
	localparam opcode_t BCC = 8'h28;

	localparam alu_sel_t ALU_ADD = 3'b000;
	localparam alu_sel_t ALU_INC = 3'b001;
	localparam alu_sel_t ALU_SUB = 3'b010;
	localparam alu_sel_t ALU_DEC = 3'b011;
	localparam alu_sel_t ALU_AND = 3'b100;
	localparam alu_sel_t ALU_OR  = 3'b101;
	localparam alu_sel_t ALU_XOR = 3'b110;
	localparam alu_sel_t ALU_NOT = 3'b111;

	localparam bus1_sel_t BUS1_PC = 2'b00;
	localparam bus1_sel_t BUS1_A  = 2'b01;
	localparam bus1_sel_t BUS1_B  = 2'b10;

	localparam bus2_sel_t BUS2_ALU  = 2'b00;
	localparam bus2_sel_t BUS2_BUS1 = 2'b01;
	localparam bus2_sel_t BUS2_MEM  = 2'b10; // From memory

	// Bit positions in the condition code register
	localparam flag_idx_t FLAG_N = 2'd3;
	localparam flag_idx_t FLAG_Z = 2'd2;
	localparam flag_idx_t FLAG_V = 2'd1;
	localparam flag_idx_t FLAG_C = 2'd0;

	typedef enum logic [2:0] {
		CLS_LOAD_IMM,
		CLS_LOAD_DIR,
		CLS_STORE,
		CLS_ALU,
		CLS_BRANCH,
		CLS_ILLEGAL
	} instr_class_e;

	typedef enum logic {
		REG_A,
		REG_B
	} reg_sel_e;

	typedef enum logic [3:0] {
		UOP_MAR_PC,   // MAR <= PC
		UOP_PC_INC,
		UOP_IR_LOAD,  // IR <= memory
		UOP_DECODE,
		UOP_MAR_MEM,  // MAR <= memory
		UOP_WAIT_MEM,
		UOP_REG_MEM,  // A or B <= memory
		UOP_STORE,
		UOP_ALU,
		UOP_PC_MEM,   // PC <= memory
		UOP_IDLE
	} micro_op_e;

endpackage
